// ==== Bender.yml ====
package:
  name: cpu16

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - datapath/alu.sv
      - datapath/register_file.sv
      - datapath/datapath.sv
      - controller/controller.sv
      - rtl/cpu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - testbench/tb_memory.sv
      - testbench/cpu_tb.sv

// ==== common/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// width of a machine word and of an address.
`define CPU_WORD_WIDTH 16
`define CPU_NUM_REGS   16

`define CPU_LINK_REG   15  // written by jal.
`define CPU_RESET_PC   0

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

   typedef logic [`CPU_WORD_WIDTH-1:0] word_t;

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_NOT  = 4'd4,
      OP_SHL  = 4'd5,
      OP_SHR  = 4'd6,
      OP_LDI  = 4'd7,
      OP_LD   = 4'd8,
      OP_ST   = 4'd9,
      OP_BR   = 4'd10,
      OP_BZ   = 4'd11,
      OP_BN   = 4'd12,
      OP_JAL  = 4'd13,
      OP_JR   = 4'd14,
      OP_HALT = 4'd15
   } opcode_e;

   // first eight entries share their codes with the opcodes.
   typedef enum logic [3:0] {
      ALU_ADD        = 4'd0,
      ALU_SUB        = 4'd1,
      ALU_AND        = 4'd2,
      ALU_OR         = 4'd3,
      ALU_NOT        = 4'd4,
      ALU_SHL        = 4'd5,
      ALU_SHR        = 4'd6,
      ALU_IMM        = 4'd7,
      ALU_LD_ADDR    = 4'd8,
      ALU_ST_ADDR    = 4'd9,
      ALU_PC_INC     = 4'd10,
      ALU_BR_TARGET  = 4'd11,
      ALU_JAL_TARGET = 4'd12,
      ALU_JR_TARGET  = 4'd13
   } alu_op_e;

   // execute states run in opcode order from EX_ADD.
   typedef enum logic [4:0] {
      IFETCH  = 5'd0,  IFETCH2 = 5'd1,  DECODE  = 5'd2,
      EX_ADD  = 5'd3,  EX_SUB  = 5'd4,  EX_AND  = 5'd5,
      EX_OR   = 5'd6,  EX_NOT  = 5'd7,  EX_SHL  = 5'd8,
      EX_SHR  = 5'd9,  EX_LDI  = 5'd10, EX_LD   = 5'd11,
      EX_ST   = 5'd12, EX_BR   = 5'd13, EX_BZ   = 5'd14,
      EX_BN   = 5'd15, EX_JAL  = 5'd16, EX_JR   = 5'd17,
      EX_QUIT = 5'd18, MEM_LD  = 5'd19, MEM_LD2 = 5'd20,
      MEM_ST  = 5'd21, WB_ALU  = 5'd22, WB_LD   = 5'd23,
      WB_JAL  = 5'd24, BR_TAKE = 5'd25, BR_NOT  = 5'd26
   } state_e;

endpackage

// ==== controller/controller.sv ====
`timescale 1ns/100ps

module controller (
   input  logic              clk,
   input  logic              reset,
   input  cpu_pkg::opcode_e  opcode,
   input  logic              zero,
   input  logic              neg,
   output logic              addr_sel,
   output logic              ir_en,
   output logic              a_en,
   output logic              b_en,
   output logic              f_en,
   output logic              mdr_en,
   output logic              pc_en,
   output logic              wb_sel,
   output logic              rf_we,
   output logic              link_sel,
   output logic              mem_we,
   output logic              halted,
   output cpu_pkg::alu_op_e  alu_op
);

   cpu_pkg::state_e state;
   cpu_pkg::state_e next_state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cpu_pkg::IFETCH;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      addr_sel   = 1'b0;
      ir_en      = 1'b0;
      a_en       = 1'b0;
      b_en       = 1'b0;
      f_en       = 1'b0;
      mdr_en     = 1'b0;
      pc_en      = 1'b0;
      wb_sel     = 1'b0;
      rf_we      = 1'b0;
      link_sel   = 1'b0;
      mem_we     = 1'b0;
      halted     = 1'b0;
      alu_op     = cpu_pkg::ALU_ADD;
      next_state = cpu_pkg::EX_QUIT;
      case (state)
         cpu_pkg::IFETCH: next_state = cpu_pkg::IFETCH2;  // memory read in flight.
         cpu_pkg::IFETCH2: begin
            ir_en      = 1'b1;
            next_state = cpu_pkg::DECODE;
         end
         cpu_pkg::DECODE: begin
            a_en       = 1'b1;
            b_en       = 1'b1;
            next_state = cpu_pkg::state_e'({1'b0, opcode} + 5'd3);  // halt lands on EX_QUIT.
         end
         cpu_pkg::EX_ADD, cpu_pkg::EX_SUB, cpu_pkg::EX_AND, cpu_pkg::EX_OR,
         cpu_pkg::EX_NOT, cpu_pkg::EX_SHL, cpu_pkg::EX_SHR, cpu_pkg::EX_LDI: begin
            alu_op     = cpu_pkg::alu_op_e'(opcode);
            f_en       = 1'b1;
            next_state = cpu_pkg::WB_ALU;
         end
         cpu_pkg::EX_LD: begin
            alu_op     = cpu_pkg::ALU_LD_ADDR;
            f_en       = 1'b1;
            next_state = cpu_pkg::MEM_LD;
         end
         cpu_pkg::EX_ST: begin
            alu_op     = cpu_pkg::ALU_ST_ADDR;
            f_en       = 1'b1;
            next_state = cpu_pkg::MEM_ST;
         end
         cpu_pkg::EX_BR, cpu_pkg::BR_TAKE: begin
            alu_op     = cpu_pkg::ALU_BR_TARGET;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::EX_BZ: next_state = zero ? cpu_pkg::BR_TAKE : cpu_pkg::BR_NOT;
         cpu_pkg::EX_BN: next_state = neg ? cpu_pkg::BR_TAKE : cpu_pkg::BR_NOT;
         cpu_pkg::EX_JAL: begin
            alu_op     = cpu_pkg::ALU_PC_INC;  // link value into f.
            f_en       = 1'b1;
            next_state = cpu_pkg::WB_JAL;
         end
         cpu_pkg::EX_JR: begin
            alu_op     = cpu_pkg::ALU_JR_TARGET;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::EX_QUIT: begin
            halted     = 1'b1;
            next_state = cpu_pkg::EX_QUIT;  // only reset leaves.
         end
         cpu_pkg::MEM_LD: begin
            addr_sel   = 1'b1;
            next_state = cpu_pkg::MEM_LD2;
         end
         cpu_pkg::MEM_LD2: begin
            addr_sel   = 1'b1;
            mdr_en     = 1'b1;
            next_state = cpu_pkg::WB_LD;
         end
         cpu_pkg::MEM_ST: begin
            addr_sel   = 1'b1;
            mem_we     = 1'b1;
            alu_op     = cpu_pkg::ALU_PC_INC;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::WB_ALU: begin
            rf_we      = 1'b1;
            alu_op     = cpu_pkg::ALU_PC_INC;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::WB_LD: begin
            wb_sel     = 1'b1;
            rf_we      = 1'b1;
            alu_op     = cpu_pkg::ALU_PC_INC;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::WB_JAL: begin
            link_sel   = 1'b1;
            rf_we      = 1'b1;
            alu_op     = cpu_pkg::ALU_JAL_TARGET;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         cpu_pkg::BR_NOT: begin
            alu_op     = cpu_pkg::ALU_PC_INC;
            pc_en      = 1'b1;
            next_state = cpu_pkg::IFETCH;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module alu (
   input  cpu_pkg::alu_op_e  op,
   input  cpu_pkg::word_t    a,
   input  cpu_pkg::word_t    b,
   input  cpu_pkg::word_t    pc,
   input  cpu_pkg::word_t    ir,
   output cpu_pkg::word_t    result
);

   cpu_pkg::word_t imm8;
   cpu_pkg::word_t ld_off;
   cpu_pkg::word_t st_off;
   cpu_pkg::word_t br_off;
   cpu_pkg::word_t pc_inc;

   assign imm8   = {{(`CPU_WORD_WIDTH-8){1'b0}}, ir[7:0]};
   assign ld_off = {{(`CPU_WORD_WIDTH-4){1'b0}}, ir[3:0]};
   assign st_off = {{(`CPU_WORD_WIDTH-4){1'b0}}, ir[11:8]};
   // offset is split around the rs field.
   assign br_off = {{(`CPU_WORD_WIDTH-8){ir[11]}}, ir[11:8], ir[3:0]};
   assign pc_inc = pc + 1'b1;

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD:        result = a + b;
         cpu_pkg::ALU_SUB:        result = a - b;
         cpu_pkg::ALU_AND:        result = a & b;
         cpu_pkg::ALU_OR:         result = a | b;
         cpu_pkg::ALU_NOT:        result = ~a;
         cpu_pkg::ALU_SHL:        result = a << 1;
         cpu_pkg::ALU_SHR:        result = a >> 1;  // logical.
         cpu_pkg::ALU_IMM:        result = imm8;
         cpu_pkg::ALU_LD_ADDR:    result = a + ld_off;
         cpu_pkg::ALU_ST_ADDR:    result = a + st_off;
         cpu_pkg::ALU_PC_INC:     result = pc_inc;
         cpu_pkg::ALU_BR_TARGET,
         cpu_pkg::ALU_JAL_TARGET: result = pc_inc + br_off;
         cpu_pkg::ALU_JR_TARGET:  result = a;
         default:                 result = '0;
      endcase
   end

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module datapath (
   input  logic              clk,
   input  logic              reset,
   input  logic              addr_sel,
   input  logic              ir_en,
   input  logic              a_en,
   input  logic              b_en,
   input  logic              f_en,
   input  logic              mdr_en,
   input  logic              pc_en,
   input  logic              wb_sel,
   input  logic              rf_we,
   input  logic              link_sel,
   input  cpu_pkg::alu_op_e  alu_op,
   output cpu_pkg::opcode_e  opcode,
   output logic              zero,
   output logic              neg,
   output cpu_pkg::word_t    mem_addr,
   output cpu_pkg::word_t    mem_wdata,
   input  cpu_pkg::word_t    mem_rdata
);

   cpu_pkg::word_t pc;
   cpu_pkg::word_t ir;
   cpu_pkg::word_t a_reg;
   cpu_pkg::word_t b_reg;
   cpu_pkg::word_t f_reg;
   cpu_pkg::word_t mdr;
   cpu_pkg::word_t alu_result;
   cpu_pkg::word_t rdata_a;
   cpu_pkg::word_t rdata_b;
   cpu_pkg::word_t wdata;
   logic [3:0]     waddr;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= cpu_pkg::word_t'(`CPU_RESET_PC);
      end else if (pc_en) begin
         pc <= alu_result;
      end
   end

   always_ff @(posedge clk) begin
      if (ir_en) ir <= mem_rdata;
      if (a_en) a_reg <= rdata_a;
      if (b_en) b_reg <= rdata_b;
      if (f_en) f_reg <= alu_result;
      if (mdr_en) mdr <= mem_rdata;
   end

   assign mem_addr  = addr_sel ? f_reg : pc;
   assign mem_wdata = b_reg;
   assign wdata     = wb_sel ? mdr : f_reg;
   assign waddr     = link_sel ? 4'(`CPU_LINK_REG) : ir[11:8];

   assign opcode = cpu_pkg::opcode_e'(ir[15:12]);
   assign zero   = (a_reg == '0);  // flags describe rs.
   assign neg    = a_reg[`CPU_WORD_WIDTH-1];

   alu u_alu (
      .op     (alu_op),
      .a      (a_reg),
      .b      (b_reg),
      .pc     (pc),
      .ir     (ir),
      .result (alu_result)
   );

   register_file u_register_file (
      .clk     (clk),
      .raddr_a (ir[7:4]),
      .raddr_b (ir[3:0]),
      .waddr   (waddr),
      .we      (rf_we),
      .wdata   (wdata),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

endmodule

// ==== datapath/register_file.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module register_file (
   input  logic            clk,
   input  logic [3:0]      raddr_a,
   input  logic [3:0]      raddr_b,
   input  logic [3:0]      waddr,
   input  logic            we,
   input  cpu_pkg::word_t  wdata,
   output cpu_pkg::word_t  rdata_a,
   output cpu_pkg::word_t  rdata_b
);

   cpu_pkg::word_t regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // reads see the old value during a write cycle.
   assign rdata_a = regs[raddr_a];
   assign rdata_b = regs[raddr_b];

endmodule

// ==== project.f ====
+incdir+common
common/cpu_pkg.sv
datapath/alu.sv
datapath/register_file.sv
datapath/datapath.sv
controller/controller.sv
rtl/cpu_top.sv
testbench/tb_memory.sv
testbench/cpu_tb.sv

// ==== rtl/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
   input  logic            clk,
   input  logic            reset,
   output cpu_pkg::word_t  mem_addr,
   output cpu_pkg::word_t  mem_wdata,
   output logic            mem_we,
   input  cpu_pkg::word_t  mem_rdata,
   output logic            halted
);

   logic              addr_sel;
   logic              ir_en;
   logic              a_en;
   logic              b_en;
   logic              f_en;
   logic              mdr_en;
   logic              pc_en;
   logic              wb_sel;
   logic              rf_we;
   logic              link_sel;
   logic              zero;
   logic              neg;
   cpu_pkg::alu_op_e  alu_op;
   cpu_pkg::opcode_e  opcode;

   controller u_controller (
      .clk      (clk),
      .reset    (reset),
      .opcode   (opcode),
      .zero     (zero),
      .neg      (neg),
      .addr_sel (addr_sel),
      .ir_en    (ir_en),
      .a_en     (a_en),
      .b_en     (b_en),
      .f_en     (f_en),
      .mdr_en   (mdr_en),
      .pc_en    (pc_en),
      .wb_sel   (wb_sel),
      .rf_we    (rf_we),
      .link_sel (link_sel),
      .mem_we   (mem_we),
      .halted   (halted),
      .alu_op   (alu_op)
   );

   datapath u_datapath (
      .clk       (clk),
      .reset     (reset),
      .addr_sel  (addr_sel),
      .ir_en     (ir_en),
      .a_en      (a_en),
      .b_en      (b_en),
      .f_en      (f_en),
      .mdr_en    (mdr_en),
      .pc_en     (pc_en),
      .wb_sel    (wb_sel),
      .rf_we     (rf_we),
      .link_sel  (link_sel),
      .alu_op    (alu_op),
      .opcode    (opcode),
      .zero      (zero),
      .neg       (neg),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_tb;

   localparam int CLK_PERIOD      = 8;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 400;
   localparam int MEM_WORDS       = 2**`CPU_WORD_WIDTH;

   logic           clk;
   logic           reset;
   cpu_pkg::word_t mem_addr;
   cpu_pkg::word_t mem_wdata;
   cpu_pkg::word_t mem_rdata;
   logic           mem_we;
   logic           halted;

   cpu_pkg::word_t exp_mem [MEM_WORDS];  // expected memory image.
   int             prog_addr;
   logic [31:0]    seed = 32'hb2c319c1;

   cpu_top uut (
      .clk       (clk),
      .reset     (reset),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   tb_memory mem_model (
      .clk   (clk),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .we    (mem_we),
      .rdata (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(CYCLES_PER_TEST * NUM_TESTS * CLK_PERIOD);
      $display("ERROR: the processor never halted before the time limit");
      $display("STATUS: FAIL");
      $fatal(1);
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic cpu_pkg::word_t fill_value(input cpu_pkg::word_t a);
      return {a[7:0], a[15:8]} ^ 16'hc35a;
   endfunction

   function automatic cpu_pkg::word_t rtype(input cpu_pkg::opcode_e op,
         input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] rt);
      return {op, rd, rs, rt};
   endfunction

   function automatic cpu_pkg::word_t ldi(input logic [3:0] rd, input logic [7:0] imm);
      return {cpu_pkg::OP_LDI, rd, imm};
   endfunction

   // signed offset split around the rs field.
   function automatic cpu_pkg::word_t branch(input cpu_pkg::opcode_e op,
         input logic [3:0] rs, input logic [7:0] off);
      return {op, off[7:4], rs, off[3:0]};
   endfunction

   function automatic cpu_pkg::word_t halt_word();
      return {cpu_pkg::OP_HALT, 12'h000};
   endfunction

   task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
         input cpu_pkg::word_t addr);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: memory word %h holds %h, expected %h",
                  $time, addr, got, exp);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_halt(input logic got_halted, input logic got_we);
      if (got_halted !== 1'b1 || got_we !== 1'b0) begin
         $display("MISMATCH at %0t ns: halted=%b mem_we=%b, expected halted=1 mem_we=0",
                  $time, got_halted, got_we);
         $display("STATUS: FAIL");
         $fatal(1);
      end
   endtask

   task automatic put(input cpu_pkg::word_t a, input cpu_pkg::word_t d);
      mem_model.load_word(a, d);
      exp_mem[a] = d;
   endtask

   task automatic expect_word(input cpu_pkg::word_t a, input cpu_pkg::word_t d);
      exp_mem[a] = d;
   endtask

   task automatic emit(input cpu_pkg::word_t instr);
      put(cpu_pkg::word_t'(prog_addr), instr);
      prog_addr++;
   endtask

   task automatic assert_reset();
      @(negedge clk);
      reset     = 1'b1;
      prog_addr = 0;
   endtask

   task automatic start_test();
      assert_reset();
      for (int a = 0; a < MEM_WORDS; a++) begin
         put(cpu_pkg::word_t'(a), fill_value(cpu_pkg::word_t'(a)));
      end
   endtask

   task automatic run_program();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      do begin
         @(negedge clk);
      end while (halted !== 1'b1);
   endtask

   task automatic check_memory();
      for (int a = 0; a < MEM_WORDS; a++) begin
         check_word(mem_model.peek_word(cpu_pkg::word_t'(a)), exp_mem[a],
                    cpu_pkg::word_t'(a));
      end
   endtask

   task automatic test_alu();
      logic [31:0]    r;
      cpu_pkg::word_t x;
      cpu_pkg::word_t y;
      cpu_pkg::word_t res [7];
      r = next_rand();
      x = {8'h00, r[23:16]};
      r = next_rand();
      y = {8'h00, r[23:16]};
      res[0] = x + y;
      res[1] = x - y;
      res[2] = x & y;
      res[3] = x | y;
      res[4] = ~x;
      res[5] = res[4] << 1;  // shifts act on ~x to reach bit 15.
      res[6] = res[4] >> 1;
      start_test();
      emit(ldi(1, x[7:0]));
      emit(ldi(2, y[7:0]));
      emit(ldi(3, 8'h80));
      emit(rtype(cpu_pkg::OP_NOT, 5, 1, 0));
      for (int i = 0; i < 7; i++) begin
         emit(rtype(cpu_pkg::opcode_e'(i), 4, (i >= 5) ? 4'd5 : 4'd1, 2));
         emit(rtype(cpu_pkg::OP_ST, 4'(i), 3, 4));
         expect_word(16'h0080 + cpu_pkg::word_t'(i), res[i]);
      end
      emit(halt_word());
      run_program();
      check_memory();
   endtask

   task automatic test_load_store();
      logic [31:0]    r;
      cpu_pkg::word_t d [4];
      start_test();
      for (int i = 0; i < 4; i++) begin
         r    = next_rand();
         d[i] = r[31:16];
         put(16'h0090 + cpu_pkg::word_t'(i), d[i]);
      end
      emit(ldi(1, 8'h8e));
      emit(rtype(cpu_pkg::OP_LD, 2, 1, 2));   // 0x8e + 2
      emit(rtype(cpu_pkg::OP_LD, 3, 1, 5));   // 0x8e + 5
      emit(ldi(4, 8'ha0));
      emit(rtype(cpu_pkg::OP_ST, 3, 4, 2));
      emit(rtype(cpu_pkg::OP_ST, 9, 4, 3));
      emit(rtype(cpu_pkg::OP_ADD, 5, 2, 3));
      emit(rtype(cpu_pkg::OP_ST, 15, 4, 5));
      emit(halt_word());
      expect_word(16'h00a0 + 3, d[0]);
      expect_word(16'h00a0 + 9, d[3]);
      expect_word(16'h00a0 + 15, d[0] + d[3]);
      run_program();
      check_memory();
   endtask

   task automatic test_branches();
      cpu_pkg::word_t   vals [3];
      cpu_pkg::opcode_e op;
      cpu_pkg::word_t   v;
      logic             taken;
      vals[0] = 16'h0000;
      vals[1] = ~16'h0000;
      vals[2] = 16'h0005;
      start_test();
      emit(ldi(1, 8'h00));
      emit(rtype(cpu_pkg::OP_NOT, 2, 1, 0));
      emit(ldi(3, 8'h05));
      emit(ldi(4, 8'hb0));
      emit(ldi(5, 8'h7a));  // taken marker.
      emit(ldi(6, 8'h0e));  // not-taken marker.
      for (int c = 0; c < 6; c++) begin
         op    = (c < 3) ? cpu_pkg::OP_BZ : cpu_pkg::OP_BN;
         v     = vals[c % 3];
         taken = (op == cpu_pkg::OP_BZ) ? (v == 16'h0000) : v[15];
         emit(branch(op, 4'(c % 3 + 1), 8'd2));
         emit(rtype(cpu_pkg::OP_ST, 4'(c), 4, 6));
         emit(branch(cpu_pkg::OP_BR, 0, 8'd1));
         emit(rtype(cpu_pkg::OP_ST, 4'(c), 4, 5));
         expect_word(16'h00b0 + cpu_pkg::word_t'(c), taken ? 16'h007a : 16'h000e);
      end
      emit(branch(cpu_pkg::OP_BR, 0, 8'd3));
      emit(rtype(cpu_pkg::OP_ST, 7, 4, 6));  // jumped over.
      emit(rtype(cpu_pkg::OP_ST, 6, 4, 5));
      emit(halt_word());
      emit(branch(cpu_pkg::OP_BR, 0, 8'hfd));
      expect_word(16'h00b6, 16'h007a);
      run_program();
      check_memory();
   endtask

   task automatic test_calls();
      cpu_pkg::word_t call_addr;
      start_test();
      emit(ldi(4, 8'hc0));
      emit(ldi(5, 8'h33));
      call_addr = cpu_pkg::word_t'(prog_addr);
      emit(branch(cpu_pkg::OP_JAL, 0, 8'd3));
      emit(rtype(cpu_pkg::OP_ST, 1, 4, 5));
      emit(halt_word());
      emit(rtype(cpu_pkg::OP_ST, 2, 4, 5));
      emit(rtype(cpu_pkg::OP_ST, 0, 4, `CPU_LINK_REG));
      emit(rtype(cpu_pkg::OP_JR, 0, `CPU_LINK_REG, 0));
      expect_word(16'h00c0, call_addr + 1);
      expect_word(16'h00c1, 16'h0033);
      run_program();
      check_memory();
   endtask

   task automatic test_halt_reset();
      start_test();
      emit(ldi(1, 8'h44));
      emit(ldi(2, 8'hd0));
      emit(rtype(cpu_pkg::OP_ST, 0, 2, 1));
      emit(halt_word());
      expect_word(16'h00d0, 16'h0044);
      run_program();
      repeat (20) begin
         @(negedge clk);
         check_halt(halted, mem_we);
      end
      check_memory();
      // second program overwrites the first from address 0.
      assert_reset();
      emit(ldi(1, 8'h55));
      emit(ldi(2, 8'hd0));
      emit(rtype(cpu_pkg::OP_ST, 1, 2, 1));
      emit(halt_word());
      expect_word(16'h00d1, 16'h0055);
      run_program();
      check_memory();
   endtask

   initial begin
      reset     = 1'b1;
      prog_addr = 0;
      test_alu();
      test_load_store();
      test_branches();
      test_calls();
      test_halt_reset();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== testbench/tb_memory.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module tb_memory (
   input  logic            clk,
   input  cpu_pkg::word_t  addr,
   input  cpu_pkg::word_t  wdata,
   input  logic            we,
   output cpu_pkg::word_t  rdata
);

   cpu_pkg::word_t mem [2**`CPU_WORD_WIDTH];

   initial begin
      rdata = '0;
   end

   // read data shows up one cycle after the address.
   always @(posedge clk) begin
      rdata <= mem[addr];
      if (we) begin
         mem[addr] = wdata;
      end
   end

   task automatic load_word(input cpu_pkg::word_t a, input cpu_pkg::word_t d);
      mem[a] = d;
   endtask

   function automatic cpu_pkg::word_t peek_word(input cpu_pkg::word_t a);
      return mem[a];
   endfunction

endmodule
